// File: list.f
+incdir+hdl
hdl/ooo_pkg.sv
hdl/fetch_unit.sv
hdl/dispatch_unit.sv
hdl/reservation_station.sv
hdl/alu_unit.sv
hdl/reorder_buffer.sv
hdl/register_file.sv
hdl/ooo_core.sv
sim/ooo_core_assert.sv
sim/ooo_core_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the core testbench with Verilator, run it, grade it from the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
    --top-module ooo_core_tb \
    -f list.f \
    -o ooo_core_sim

# the log decides the result, so a stopped run still reaches the search
./obj_dir/ooo_core_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^sim passed$" sim.log; then
    echo "run.sh: pass message found"
    exit 0
else
    echo "run.sh: pass message missing"
    exit 1
fi

// File: sim/ooo_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ooo_cfg.svh"

module ooo_core_tb import ooo_pkg::*; ();

    // program is the random ops plus the closing halt
    localparam int PROG_WORDS      = 96;
    localparam int PROG_OPS        = PROG_WORDS - 1;
    localparam int RESET_CYCLES    = 16;
    localparam int HALT_WAIT       = 20;
    localparam int WATCHDOG_CYCLES = PROG_WORDS * 30;
    localparam int MEM_WORDS       = 256;

    localparam logic [6:0] OPC_REG   = 7'b0110011;
    localparam logic [6:0] OPC_IMM   = 7'b0010011;
    // system opcode, not an alu op
    localparam inst_t      HALT_WORD = 32'h0000_0073;

    logic     clock;
    logic     reset;
    inst_t    imem_data;
    word_t    imem_addr;
    logic     commit_valid;
    reg_idx_t commit_idx;
    word_t    commit_data;
    word_t    commit_pc;
    logic     halted;

    integer   seed;
    int       commit_count;
    word_t    fetch_addr;
    inst_t    imem [MEM_WORDS];

    // per instruction record, base op 0..9 = add sub and or xor slt sltu sll srl sra
    int          prog_base   [PROG_OPS];
    logic        prog_is_imm [PROG_OPS];
    reg_idx_t    prog_rd     [PROG_OPS];
    reg_idx_t    prog_rs1    [PROG_OPS];
    reg_idx_t    prog_rs2    [PROG_OPS];
    logic [11:0] prog_imm    [PROG_OPS];
    word_t       model_regs  [`OOO_REG_NUM];

    // async instruction memory, word addressed
    assign imem_data = imem[imem_addr[9:2]];

    ooo_core UUT (
        .clock        (clock),
        .reset        (reset),
        .imem_data    (imem_data),
        .imem_addr    (imem_addr),
        .commit_valid (commit_valid),
        .commit_idx   (commit_idx),
        .commit_data  (commit_data),
        .commit_pc    (commit_pc),
        .halted       (halted)
    );

    bind ooo_core ooo_core_assert core_checks (
        .clock        (clock),
        .reset        (reset),
        .imem_addr    (imem_addr),
        .commit_valid (commit_valid),
        .commit_idx   (commit_idx),
        .commit_data  (commit_data),
        .commit_pc    (commit_pc),
        .halted       (halted)
    );

    // 100 ns clock
    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    ////////////////////////////////////////////////////////////////////////////
    // reporting
    ////////////////////////////////////////////////////////////////////////////

    task automatic stop_run();
        $display("sim failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
            stop_run();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // random program
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [2:0] funct3_for(input int base);
        case (base)
            2: return 3'b111;
            3: return 3'b110;
            4: return 3'b100;
            5: return 3'b010;
            6: return 3'b011;
            7: return 3'b001;
            8, 9: return 3'b101;
            default: return 3'b000;
        endcase
    endfunction

    // three in four picks land on x1..x4 for frequent dependency chains
    // x0 on about one in sixteen
    task automatic pick_reg(output reg_idx_t idx);
        logic [31:0] bits;
        bits = $random(seed);
        if (bits[1:0] != 2'b00)
            idx = 5'd1 + {3'b000, bits[3:2]};
        else if (bits[3:2] == 2'b00)
            idx = 5'd0;
        else
            idx = bits[8:4];
    endtask

    task automatic build_program();
        logic [31:0] bits;
        int          kind;
        logic [2:0]  f3;
        logic [6:0]  f7;
        // spare words are halts tagged with their own address
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = {17'd0, i[7:0], 7'b1111111};
        end
        for (int n = 0; n < PROG_OPS; n++) begin
            bits = $random(seed);
            kind = int'(bits[7:0]) % 19;
            prog_is_imm[n] = kind >= 10;
            // immediate forms have no sub
            prog_base[n] = (kind < 10) ? kind : ((kind == 10) ? 0 : kind - 9);
            pick_reg(prog_rd[n]);
            pick_reg(prog_rs1[n]);
            pick_reg(prog_rs2[n]);
            f3 = funct3_for(prog_base[n]);
            f7 = (prog_base[n] == 1 || prog_base[n] == 9) ? 7'b0100000 : 7'b0000000;
            // shift immediates carry funct7 over the shamt
            if (prog_base[n] >= 7)
                prog_imm[n] = {f7, bits[12:8]};
            else
                prog_imm[n] = bits[31:20];
            if (prog_is_imm[n])
                imem[n] = {prog_imm[n], prog_rs1[n], f3, prog_rd[n], OPC_IMM};
            else
                imem[n] = {f7, prog_rs2[n], prog_rs1[n], f3, prog_rd[n], OPC_REG};
        end
        imem[PROG_OPS] = HALT_WORD;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // in-order reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] reference_alu(input int base, input logic [31:0] a,
                                                  input logic [31:0] b);
        case (base)
            1: return a - b;
            2: return a & b;
            3: return a | b;
            4: return a ^ b;
            5: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            6: return (a < b) ? 32'd1 : 32'd0;
            7: return a << b[4:0];
            8: return a >> b[4:0];
            9: return 32'($signed(a) >>> b[4:0]);
            default: return a + b;
        endcase
    endfunction

    task automatic reference_step(input int n, output reg_idx_t idx, output word_t data,
                                  output word_t pc);
        word_t a;
        word_t b;
        a = model_regs[prog_rs1[n]];
        if (prog_is_imm[n])
            b = {{20{prog_imm[n][11]}}, prog_imm[n]};
        else
            b = model_regs[prog_rs2[n]];
        data = reference_alu(prog_base[n], a, b);
        idx  = prog_rd[n];
        pc   = word_t'(`OOO_RESET_PC) + word_t'(4 * n);
        // x0 keeps its zero, the result still shows on the commit
        if (prog_rd[n] != 5'd0)
            model_regs[prog_rd[n]] = data;
    endtask

    task automatic check_commit();
        reg_idx_t exp_idx;
        word_t    exp_data;
        word_t    exp_pc;
        if (commit_count >= PROG_OPS) begin
            $display("commit seen past the last program instruction, pc 0x%h", commit_pc);
            stop_run();
        end else begin
            reference_step(commit_count, exp_idx, exp_data, exp_pc);
            // pc first, an out-of-order commit shows up here
            check_value("commit_pc", commit_pc, exp_pc);
            check_value("commit_idx", 32'(commit_idx), 32'(exp_idx));
            check_value("commit_data", commit_data, exp_data);
            commit_count++;
        end
    endtask

    // fetch address holds on a stall, else moves one word on
    task automatic check_fetch_step();
        if (imem_addr !== fetch_addr)
            check_value("imem_addr", imem_addr, fetch_addr + 32'd4);
        fetch_addr = imem_addr;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin : run_test
        seed         = 17;
        commit_count = 0;
        reset        = 1'b1;
        for (int r = 0; r < `OOO_REG_NUM; r++) begin
            model_regs[r] = '0;
        end
        build_program();

        // quiet outputs through reset, sampled mid-cycle
        for (int c = 0; c < RESET_CYCLES; c++) begin
            @(posedge clock);
            if (c == RESET_CYCLES - 1)
                reset <= 1'b0;
            @(negedge clock);
            check_value("commit_valid", 32'(commit_valid), 32'd0);
            check_value("halted", 32'(halted), 32'd0);
            check_value("imem_addr", imem_addr, word_t'(`OOO_RESET_PC));
        end
        fetch_addr = imem_addr;

        // first cycle out of reset
        @(negedge clock);
        check_value("commit_valid", 32'(commit_valid), 32'd0);
        check_value("halted", 32'(halted), 32'd0);
        check_fetch_step();

        // every commit against the model until the halt retires
        while (!halted) begin
            @(negedge clock);
            check_fetch_step();
            if (commit_valid)
                check_commit();
        end
        check_value("commit count", commit_count, PROG_OPS);

        // core stays parked
        repeat (HALT_WAIT) begin
            @(negedge clock);
            check_value("commit_valid", 32'(commit_valid), 32'd0);
            check_value("halted", 32'(halted), 32'd1);
            check_value("imem_addr", imem_addr, fetch_addr);
        end

        $display("sim passed");
        $finish;
    end

    // bound on the whole run
    initial begin : watchdog
        repeat (RESET_CYCLES + WATCHDOG_CYCLES) @(posedge clock);
        $display("timeout, core did not halt within %0d cycles", WATCHDOG_CYCLES);
        stop_run();
    end

endmodule

`default_nettype wire

// File: sim/ooo_core_assert.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_core_assert import ooo_pkg::*; (
    input logic     clock,
    input logic     reset,
    input word_t    imem_addr,
    input logic     commit_valid,
    input reg_idx_t commit_idx,
    input word_t    commit_data,
    input word_t    commit_pc,
    input logic     halted
);

    // nothing retires once the halt is through
    no_commit_when_halted: assert property (
        @(posedge clock) disable iff (reset) halted |-> !commit_valid
    ) else $error("commit_valid high while halted");

    // halted is sticky until the next reset
    halted_sticky: assert property (
        @(posedge clock) disable iff (reset) halted |=> halted
    ) else $error("halted dropped without reset");

    // control outputs always known out of reset
    control_known: assert property (
        @(posedge clock) disable iff (reset) !$isunknown({imem_addr, commit_valid, halted})
    ) else $error("unknown value on imem_addr, commit_valid or halted");

    // commit payload known whenever it is strobed
    commit_known: assert property (
        @(posedge clock) disable iff (reset)
            commit_valid |-> !$isunknown({commit_idx, commit_data, commit_pc})
    ) else $error("unknown commit payload with commit_valid high");

endmodule

`default_nettype wire

// File: hdl/ooo_core.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_core import ooo_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  inst_t    imem_data,
    output word_t    imem_addr,
    output logic     commit_valid,
    output reg_idx_t commit_idx,
    output word_t    commit_data,
    output word_t    commit_pc,
    output logic     halted
);

    // fetch to dispatch
    inst_t    inst;
    word_t    inst_pc;
    logic     inst_valid;
    logic     stall;
    logic     halt_dispatched;

    // dispatch to station and rob
    logic     dispatch_valid;
    alu_op_t  dispatch_op;
    rob_tag_t dispatch_tag;
    logic     src1_ready;
    rob_tag_t src1_tag;
    word_t    src1_value;
    logic     src2_ready;
    rob_tag_t src2_tag;
    word_t    src2_value;
    reg_idx_t dispatch_rd;
    word_t    dispatch_pc;
    logic     dispatch_halt;

    // rob lookups and status
    logic     rob_full;
    rob_tag_t rob_tail_tag;
    rob_tag_t look1_tag;
    rob_tag_t look2_tag;
    logic     look1_done;
    logic     look2_done;
    word_t    look1_value;
    word_t    look2_value;
    rob_tag_t commit_tag;

    // register file reads
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    word_t    rs1_value;
    word_t    rs2_value;

    // station to alu, alu onto the data bus
    logic     rs_full;
    logic     issue_valid;
    alu_op_t  issue_op;
    rob_tag_t issue_tag;
    word_t    issue_a;
    word_t    issue_b;
    logic     cdb_valid;
    rob_tag_t cdb_tag;
    word_t    cdb_value;

    ////////////////////////////////////////////////////////////////////////////
    // front end
    ////////////////////////////////////////////////////////////////////////////

    fetch_unit fetch (
        .clock, .reset, .imem_data, .stall, .halt_dispatched,
        .imem_addr, .inst, .inst_pc, .inst_valid
    );

    dispatch_unit dispatch (
        .clock, .reset, .inst, .inst_pc, .inst_valid,
        .rs_full, .rob_full,
        .rob_tail_tag, .look1_done, .look1_value, .look2_done, .look2_value,
        .look1_tag, .look2_tag,
        .rs1_value, .rs2_value, .rs1_idx, .rs2_idx,
        .cdb_valid, .cdb_tag, .cdb_value,
        .commit_valid, .commit_tag,
        .stall, .halt_dispatched,
        .dispatch_valid, .dispatch_op, .dispatch_tag,
        .src1_ready, .src1_tag, .src1_value,
        .src2_ready, .src2_tag, .src2_value,
        .dispatch_rd, .dispatch_pc, .dispatch_halt
    );

    ////////////////////////////////////////////////////////////////////////////
    // issue, execute, commit
    ////////////////////////////////////////////////////////////////////////////

    reservation_station station (
        .clock, .reset, .dispatch_valid, .dispatch_op, .dispatch_tag,
        .src1_ready, .src1_tag, .src1_value,
        .src2_ready, .src2_tag, .src2_value,
        .cdb_valid, .cdb_tag, .cdb_value,
        .rs_full, .issue_valid, .issue_op, .issue_tag, .issue_a, .issue_b
    );

    alu_unit alu (
        .clock, .reset, .issue_valid, .issue_op, .issue_tag, .issue_a, .issue_b,
        .cdb_valid, .cdb_tag, .cdb_value
    );

    reorder_buffer rob (
        .clock, .reset, .dispatch_valid, .dispatch_rd, .dispatch_pc, .dispatch_halt,
        .cdb_valid, .cdb_tag, .cdb_value, .look1_tag, .look2_tag,
        .rob_tail_tag, .rob_full,
        .look1_done, .look1_value, .look2_done, .look2_value,
        .commit_valid, .commit_tag, .commit_idx, .commit_data, .commit_pc, .halted
    );

    register_file regs (
        .clock, .reset, .rs1_idx, .rs2_idx, .commit_valid, .commit_idx, .commit_data,
        .rs1_value, .rs2_value
    );

endmodule

`default_nettype wire

// File: hdl/register_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "ooo_cfg.svh"

module register_file import ooo_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  reg_idx_t rs1_idx,
    input  reg_idx_t rs2_idx,
    input  logic     commit_valid,
    input  reg_idx_t commit_idx,
    input  word_t    commit_data,
    output word_t    rs1_value,
    output word_t    rs2_value
);

    word_t regs [`OOO_REG_NUM];

    // x0 reads as zero
    assign rs1_value = (rs1_idx == reg_idx_t'(0)) ? word_t'(0) : regs[rs1_idx];
    assign rs2_value = (rs2_idx == reg_idx_t'(0)) ? word_t'(0) : regs[rs2_idx];

    // commit write port
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int r = 0; r < `OOO_REG_NUM; r++) begin
                regs[r] <= '0;
            end
        end else if (commit_valid && commit_idx != reg_idx_t'(0)) begin
            regs[commit_idx] <= commit_data;
        end
    end

endmodule

`default_nettype wire

// File: hdl/reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "ooo_cfg.svh"

module reorder_buffer import ooo_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  logic     dispatch_valid,
    input  reg_idx_t dispatch_rd,
    input  word_t    dispatch_pc,
    input  logic     dispatch_halt,
    input  logic     cdb_valid,
    input  rob_tag_t cdb_tag,
    input  word_t    cdb_value,
    input  rob_tag_t look1_tag,
    input  rob_tag_t look2_tag,
    output rob_tag_t rob_tail_tag,
    output logic     rob_full,
    output logic     look1_done,
    output word_t    look1_value,
    output logic     look2_done,
    output word_t    look2_value,
    output logic     commit_valid,
    output rob_tag_t commit_tag,
    output reg_idx_t commit_idx,
    output word_t    commit_data,
    output word_t    commit_pc,
    output logic     halted
);

    localparam int CW = $clog2(`OOO_ROB_SIZE) + 1;

    rob_tag_t                head;
    rob_tag_t                tail;
    logic [CW-1:0]           count;
    logic [`OOO_ROB_SIZE-1:0] done;
    logic [`OOO_ROB_SIZE-1:0] is_halt;
    reg_idx_t                rd    [`OOO_ROB_SIZE];
    word_t                   pc    [`OOO_ROB_SIZE];
    word_t                   value [`OOO_ROB_SIZE];
    logic                    retire;

    assign rob_tail_tag = tail;
    assign rob_full     = count == CW'(`OOO_ROB_SIZE);

    // operand lookups for dispatch
    assign look1_done  = done[look1_tag];
    assign look1_value = value[look1_tag];
    assign look2_done  = done[look2_tag];
    assign look2_value = value[look2_tag];

    // head leaves once done, a halt retires without a register write
    assign retire       = count != '0 && done[head];
    assign commit_valid = retire && !is_halt[head];
    assign commit_tag   = head;
    assign commit_idx   = rd[head];
    assign commit_data  = value[head];
    assign commit_pc    = pc[head];

    ////////////////////////////////////////////////////////////////////////////
    // pointers, done bits, halted
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            head   <= '0;
            tail   <= '0;
            count  <= '0;
            done   <= '0;
            halted <= 1'b0;
        end else begin
            if (cdb_valid) done[cdb_tag] <= 1'b1;
            // allocate clears done, the slot is never the bus tag
            if (dispatch_valid) begin
                done[tail] <= 1'b0;
                tail       <= tail + rob_tag_t'(1);
            end
            if (retire) begin
                head <= head + rob_tag_t'(1);
                if (is_halt[head]) halted <= 1'b1;
            end
            count <= count + CW'(dispatch_valid) - CW'(retire);
        end
    end

    // entry payload
    always_ff @(posedge clock) begin
        if (cdb_valid) value[cdb_tag] <= cdb_value;
        if (dispatch_valid) begin
            rd[tail]      <= dispatch_rd;
            pc[tail]      <= dispatch_pc;
            is_halt[tail] <= dispatch_halt;
        end
    end

endmodule

`default_nettype wire

// File: hdl/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module alu_unit import ooo_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  logic     issue_valid,
    input  alu_op_t  issue_op,
    input  rob_tag_t issue_tag,
    input  word_t    issue_a,
    input  word_t    issue_b,
    output logic     cdb_valid,
    output rob_tag_t cdb_tag,
    output word_t    cdb_value
);

    word_t      result;
    logic [4:0] shamt;

    // shift amount from the low bits only
    assign shamt = issue_b[4:0];

    always_comb begin
        case (issue_op)
            ALU_SUB:  result = issue_a - issue_b;
            ALU_AND:  result = issue_a & issue_b;
            ALU_OR:   result = issue_a | issue_b;
            ALU_XOR:  result = issue_a ^ issue_b;
            ALU_SLT:  result = word_t'($signed(issue_a) < $signed(issue_b));
            ALU_SLTU: result = word_t'(issue_a < issue_b);
            ALU_SLL:  result = issue_a << shamt;
            ALU_SRL:  result = issue_a >> shamt;
            ALU_SRA:  result = word_t'($signed(issue_a) >>> shamt);
            default:  result = issue_a + issue_b;
        endcase
    end

    // bus valid, one cycle after issue
    always_ff @(posedge clock) begin
        if (reset) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= issue_valid;
        end
    end

    // bus payload
    always_ff @(posedge clock) begin
        cdb_tag   <= issue_tag;
        cdb_value <= result;
    end

endmodule

`default_nettype wire

// File: hdl/reservation_station.sv
`timescale 1ns/1ps
`default_nettype none

`include "ooo_cfg.svh"

module reservation_station import ooo_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  logic     dispatch_valid,
    input  alu_op_t  dispatch_op,
    input  rob_tag_t dispatch_tag,
    input  logic     src1_ready,
    input  rob_tag_t src1_tag,
    input  word_t    src1_value,
    input  logic     src2_ready,
    input  rob_tag_t src2_tag,
    input  word_t    src2_value,
    input  logic     cdb_valid,
    input  rob_tag_t cdb_tag,
    input  word_t    cdb_value,
    output logic     rs_full,
    output logic     issue_valid,
    output alu_op_t  issue_op,
    output rob_tag_t issue_tag,
    output word_t    issue_a,
    output word_t    issue_b
);

    localparam int RW = $clog2(`OOO_RS_SIZE);

    logic [`OOO_RS_SIZE-1:0] valid;
    logic [`OOO_RS_SIZE-1:0] rdy1;
    logic [`OOO_RS_SIZE-1:0] rdy2;
    logic [`OOO_RS_SIZE-1:0] ready;
    alu_op_t                 op   [`OOO_RS_SIZE];
    rob_tag_t                tag  [`OOO_RS_SIZE];
    rob_tag_t                tag1 [`OOO_RS_SIZE];
    rob_tag_t                tag2 [`OOO_RS_SIZE];
    word_t                   val1 [`OOO_RS_SIZE];
    word_t                   val2 [`OOO_RS_SIZE];
    logic [RW-1:0]           free_idx;
    logic [RW-1:0]           issue_idx;

    assign ready       = valid & rdy1 & rdy2;
    assign rs_full     = &valid;
    assign issue_valid = |ready;

    // lowest free slot and lowest ready entry, scanned from the top
    always_comb begin
        free_idx  = '0;
        issue_idx = '0;
        for (int i = `OOO_RS_SIZE - 1; i >= 0; i--) begin
            if (!valid[i]) free_idx = RW'(i);
            if (ready[i]) issue_idx = RW'(i);
        end
    end

    assign issue_op  = op[issue_idx];
    assign issue_tag = tag[issue_idx];
    assign issue_a   = val1[issue_idx];
    assign issue_b   = val2[issue_idx];

    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= '0;
        end else begin
            // wakeup from the bus
            if (cdb_valid) begin
                for (int i = 0; i < `OOO_RS_SIZE; i++) begin
                    if (valid[i] && !rdy1[i] && tag1[i] == cdb_tag) begin
                        rdy1[i] <= 1'b1;
                        val1[i] <= cdb_value;
                    end
                    if (valid[i] && !rdy2[i] && tag2[i] == cdb_tag) begin
                        rdy2[i] <= 1'b1;
                        val2[i] <= cdb_value;
                    end
                end
            end
            // issued entry leaves
            if (issue_valid) valid[issue_idx] <= 1'b0;
            // new entry into a free slot
            if (dispatch_valid) begin
                valid[free_idx] <= 1'b1;
                op[free_idx]    <= dispatch_op;
                tag[free_idx]   <= dispatch_tag;
                rdy1[free_idx]  <= src1_ready;
                tag1[free_idx]  <= src1_tag;
                val1[free_idx]  <= src1_value;
                rdy2[free_idx]  <= src2_ready;
                tag2[free_idx]  <= src2_tag;
                val2[free_idx]  <= src2_value;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/dispatch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "ooo_cfg.svh"

module dispatch_unit import ooo_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  inst_t    inst,
    input  word_t    inst_pc,
    input  logic     inst_valid,
    input  logic     rs_full,
    input  logic     rob_full,
    input  rob_tag_t rob_tail_tag,
    input  logic     look1_done,
    input  word_t    look1_value,
    input  logic     look2_done,
    input  word_t    look2_value,
    output rob_tag_t look1_tag,
    output rob_tag_t look2_tag,
    input  word_t    rs1_value,
    input  word_t    rs2_value,
    output reg_idx_t rs1_idx,
    output reg_idx_t rs2_idx,
    input  logic     cdb_valid,
    input  rob_tag_t cdb_tag,
    input  word_t    cdb_value,
    input  logic     commit_valid,
    input  rob_tag_t commit_tag,
    output logic     stall,
    output logic     halt_dispatched,
    output logic     dispatch_valid,
    output alu_op_t  dispatch_op,
    output rob_tag_t dispatch_tag,
    output logic     src1_ready,
    output rob_tag_t src1_tag,
    output word_t    src1_value,
    output logic     src2_ready,
    output rob_tag_t src2_tag,
    output word_t    src2_value,
    output reg_idx_t dispatch_rd,
    output word_t    dispatch_pc,
    output logic     dispatch_halt
);

    logic [6:0]              opcode;
    logic [2:0]              funct3;
    logic                    is_op;
    logic                    is_imm;
    word_t                   imm;
    alu_op_t                 op;
    logic [`OOO_REG_NUM-1:0] busy;
    rob_tag_t                map_tag [`OOO_REG_NUM];
    logic                    halt_seen;
    logic [`OOO_XLEN:0]      pick1;
    logic [`OOO_XLEN:0]      pick2;

    // regfile, then done rob entry, then the bus this cycle, else wait on tag
    function automatic logic [`OOO_XLEN:0] pick_source(
        input logic     busy_bit,
        input word_t    rf_value,
        input rob_tag_t tag,
        input logic     done,
        input word_t    done_value
    );
        if (!busy_bit) return {1'b1, rf_value};
        if (done) return {1'b1, done_value};
        if (cdb_valid && cdb_tag == tag) return {1'b1, cdb_value};
        return {1'b0, rf_value};
    endfunction

    // decode, anything but OP / OP-IMM is the halt
    assign opcode        = inst[6:0];
    assign funct3        = inst[14:12];
    assign is_op         = opcode == 7'b0110011;
    assign is_imm        = opcode == 7'b0010011;
    assign dispatch_halt = !is_op && !is_imm;
    assign imm           = {{20{inst[31]}}, inst[31:20]};

    always_comb begin
        case (funct3)
            3'b000: op = (is_op && inst[30]) ? ALU_SUB : ALU_ADD;
            3'b001: op = ALU_SLL;
            3'b010: op = ALU_SLT;
            3'b011: op = ALU_SLTU;
            3'b100: op = ALU_XOR;
            3'b101: op = inst[30] ? ALU_SRA : ALU_SRL;
            3'b110: op = ALU_OR;
            default: op = ALU_AND;
        endcase
    end

    // halt runs through the alu as an add of zeros
    assign dispatch_op  = dispatch_halt ? ALU_ADD : op;
    assign dispatch_rd  = dispatch_halt ? reg_idx_t'(0) : inst[11:7];
    assign dispatch_pc  = inst_pc;
    assign dispatch_tag = rob_tail_tag;

    assign stall           = rs_full || rob_full || halt_seen;
    assign dispatch_valid  = inst_valid && !stall;
    assign halt_dispatched = dispatch_valid && dispatch_halt;

    ////////////////////////////////////////////////////////////////////////////
    // operand sourcing
    ////////////////////////////////////////////////////////////////////////////

    assign rs1_idx   = inst[19:15];
    assign rs2_idx   = inst[24:20];
    assign look1_tag = map_tag[rs1_idx];
    assign look2_tag = map_tag[rs2_idx];
    assign src1_tag  = look1_tag;
    assign src2_tag  = look2_tag;

    assign pick1 = pick_source(busy[rs1_idx], rs1_value, look1_tag, look1_done, look1_value);
    assign pick2 = pick_source(busy[rs2_idx], rs2_value, look2_tag, look2_done, look2_value);

    always_comb begin
        {src1_ready, src1_value} = pick1;
        {src2_ready, src2_value} = pick2;
        if (dispatch_halt) begin
            {src1_ready, src1_value} = {1'b1, word_t'(0)};
            {src2_ready, src2_value} = {1'b1, word_t'(0)};
        end else if (is_imm) begin
            {src2_ready, src2_value} = {1'b1, imm};
        end
    end

    // map table, a new producer overrides a commit clear
    always_ff @(posedge clock) begin
        if (reset) begin
            busy      <= '0;
            halt_seen <= 1'b0;
        end else begin
            if (commit_valid) begin
                for (int r = 0; r < `OOO_REG_NUM; r++) begin
                    if (busy[r] && map_tag[r] == commit_tag) busy[r] <= 1'b0;
                end
            end
            // x0 never gets a producer
            if (dispatch_valid && dispatch_rd != reg_idx_t'(0)) begin
                busy[dispatch_rd]    <= 1'b1;
                map_tag[dispatch_rd] <= dispatch_tag;
            end
            if (halt_dispatched) halt_seen <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hdl/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "ooo_cfg.svh"

module fetch_unit import ooo_pkg::*; (
    input  logic  clock,
    input  logic  reset,
    input  inst_t imem_data,
    input  logic  stall,
    input  logic  halt_dispatched,
    output word_t imem_addr,
    output inst_t inst,
    output word_t inst_pc,
    output logic  inst_valid
);

    fetch_state_t state;
    word_t        pc;

    // memory answers within the cycle
    assign imem_addr = pc;

    // run/halted machine, pc and valid bit
    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= fetch_running;
            pc         <= word_t'(`OOO_RESET_PC);
            inst_valid <= 1'b0;
        end else begin
            case (state)
                fetch_running: begin
                    if (halt_dispatched) begin
                        state <= fetch_halted;
                    end
                    if (!stall) begin
                        pc <= pc + word_t'(4);
                        // whatever follows the halt is dropped
                        inst_valid <= !halt_dispatched;
                    end
                end
                default: begin
                    inst_valid <= 1'b0;
                end
            endcase
        end
    end

    // instruction latch, held on stall
    always_ff @(posedge clock) begin
        if (!stall) begin
            inst    <= imem_data;
            inst_pc <= pc;
        end
    end

endmodule

`default_nettype wire

// File: hdl/ooo_pkg.sv
`default_nettype none

`include "ooo_cfg.svh"

package ooo_pkg;

    // data and instruction words
    typedef logic [`OOO_XLEN-1:0] word_t;
    typedef logic [31:0] inst_t;

    // register index and rob tag
    typedef logic [$clog2(`OOO_REG_NUM)-1:0] reg_idx_t;
    typedef logic [$clog2(`OOO_ROB_SIZE)-1:0] rob_tag_t;

    // alu operation codes
    typedef logic [3:0] alu_op_t;

    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_AND  = 4'd2;
    localparam alu_op_t ALU_OR   = 4'd3;
    localparam alu_op_t ALU_XOR  = 4'd4;
    localparam alu_op_t ALU_SLT  = 4'd5;
    localparam alu_op_t ALU_SLTU = 4'd6;
    localparam alu_op_t ALU_SLL  = 4'd7;
    localparam alu_op_t ALU_SRL  = 4'd8;
    localparam alu_op_t ALU_SRA  = 4'd9;

    // fetch run state
    typedef enum logic {
        fetch_running,
        fetch_halted
    } fetch_state_t;

endpackage

`default_nettype wire

// File: hdl/ooo_cfg.svh
`ifndef OOO_CFG_SVH
`define OOO_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// core sizes
////////////////////////////////////////////////////////////////////////////

// data path width
`define OOO_XLEN 32

// architectural registers x0..x31
`define OOO_REG_NUM 32

// reorder buffer depth, power of two so the pointers wrap on their own
`define OOO_ROB_SIZE 8

// alu station depth
`define OOO_RS_SIZE 4

// first fetch address out of reset
`define OOO_RESET_PC 0

`endif
